// ==== scratchpad_mem.f ====
+incdir+include
verilog/scratchpad_pkg.sv
verilog/mem_rtl.sv
verilog/lsu_mem_port.sv
verilog/scratchpad_mem.sv
dv/scratchpad_mem_assert.sv
dv/scratchpad_mem_tb.sv

// ==== Bender.yml ====
package:
  name: scratchpad_mem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/scratchpad_pkg.sv
      - verilog/mem_rtl.sv
      - verilog/lsu_mem_port.sv
      - verilog/scratchpad_mem.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/scratchpad_mem_assert.sv
      - dv/scratchpad_mem_tb.sv

// ==== dv/scratchpad_mem_tb.sv ====
`timescale 1ns/1ps

`include "scratchpad_consts.svh"

module scratchpad_mem_tb;
    import scratchpad_pkg::*;

    localparam int          N_OPS          = 3000;
    localparam int          BYTES_PER_WORD = `SCRATCH_WORD_W / 8;
    localparam int          NUM_BYTES      = `SCRATCH_NUM_WORDS * BYTES_PER_WORD;
    localparam int          CYCLE_LIMIT    = N_OPS + `SCRATCH_NUM_WORDS + 50;
    localparam logic [31:0] LCG_SEED       = 32'd70149;

    logic       clk;
    logic       reset;
    logic       lsu_req;
    logic       lsu_we;
    byte_addr_t lsu_addr;
    mem_size_t  lsu_size;
    logic       lsu_signed;
    word_t      lsu_wdata;
    logic       lsu_load_valid;
    word_t      lsu_load_data;
    logic       lsu_misaligned;
    logic       fetch_en;
    word_addr_t fetch_addr;
    word_t      fetch_data;

    // reference model, one entry per byte address
    logic [7:0]  mem_bytes [NUM_BYTES];
    logic [31:0] lcg_state;
    word_addr_t  last_store_word;

    // expected responses, each tagged with the cycle it is due in
    int    ld_due[$];
    word_t ld_exp[$];
    int    mis_due[$];
    int    fetch_due[$];
    word_t fetch_q[$];
    word_t fetch_exp;
    logic  fetch_known;

    int cycle;
    int timeout_cycles;
    int data_errors;
    int pulse_errors;

    scratchpad_mem UUT (
        .clk            (clk),
        .reset          (reset),
        .lsu_req        (lsu_req),
        .lsu_we         (lsu_we),
        .lsu_addr       (lsu_addr),
        .lsu_size       (lsu_size),
        .lsu_signed     (lsu_signed),
        .lsu_wdata      (lsu_wdata),
        .lsu_load_valid (lsu_load_valid),
        .lsu_load_data  (lsu_load_data),
        .lsu_misaligned (lsu_misaligned),
        .fetch_en       (fetch_en),
        .fetch_addr     (fetch_addr),
        .fetch_data     (fetch_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // -------------------------------------------------------------------------
    // random numbers and reference model
    // -------------------------------------------------------------------------

    // the upper half of the state has a much longer period than the low bits
    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    function automatic word_t rand_word();
        word_t w;
        w[31:16] = next_rand();
        w[15:0]  = next_rand();
        return w;
    endfunction

    function automatic word_t model_word(input word_addr_t wa);
        word_t w;
        for (int i = 0; i < BYTES_PER_WORD; i++) begin
            w[i*8 +: 8] = mem_bytes[int'(wa) * BYTES_PER_WORD + i];
        end
        return w;
    endfunction

    function automatic logic is_misaligned(input byte_addr_t a, input mem_size_t sz);
        if (sz == `SCRATCH_SIZE_HALF) begin
            return a[0];
        end
        if (sz == `SCRATCH_SIZE_WORD) begin
            return (a[1:0] != 2'b00);
        end
        return 1'b0;
    endfunction

    // bytes sit little endian inside a word, lowest address in bits 7:0
    function automatic word_t model_load(input byte_addr_t a, input mem_size_t sz,
                                         input logic sgn);
        logic [7:0]  b0;
        logic [15:0] h0;
        word_t       result;
        case (sz)
            `SCRATCH_SIZE_BYTE: begin
                b0     = mem_bytes[a];
                result = sgn ? {{24{b0[7]}}, b0} : {24'h0, b0};
            end
            `SCRATCH_SIZE_HALF: begin
                h0     = {mem_bytes[int'(a) + 1], mem_bytes[a]};
                result = sgn ? {{16{h0[15]}}, h0} : {16'h0, h0};
            end
            default: result = model_word(word_addr_t'(a / BYTES_PER_WORD));
        endcase
        return result;
    endfunction

    function automatic void model_store(input byte_addr_t a, input mem_size_t sz,
                                        input word_t data);
        int n;
        case (sz)
            `SCRATCH_SIZE_BYTE: n = 1;
            `SCRATCH_SIZE_HALF: n = 2;
            default:            n = BYTES_PER_WORD;
        endcase
        for (int i = 0; i < n; i++) begin
            mem_bytes[int'(a) + i] = data[i*8 +: 8];
        end
    endfunction

    // -------------------------------------------------------------------------
    // stimulus and checks
    // -------------------------------------------------------------------------

    task automatic set_idle();
        lsu_req  = 1'b0;
        lsu_we   = 1'b0;
        fetch_en = 1'b0;
    endtask

    // a request driven now is sampled at the next edge, so results are due
    // two edges from the current cycle count and misaligned flags one
    task automatic issue_lsu(input logic we, input byte_addr_t a, input mem_size_t sz,
                             input logic sgn, input word_t data);
        lsu_req    = 1'b1;
        lsu_we     = we;
        lsu_addr   = a;
        lsu_size   = sz;
        lsu_signed = sgn;
        lsu_wdata  = data;
        if (is_misaligned(a, sz)) begin
            mis_due.push_back(cycle + 1);
        end else if (we) begin
            model_store(a, sz, data);
            last_store_word = word_addr_t'(a / BYTES_PER_WORD);
        end else begin
            ld_due.push_back(cycle + 2);
            ld_exp.push_back(model_load(a, sz, sgn));
        end
    endtask

    task automatic issue_fetch(input word_addr_t wa);
        fetch_en   = 1'b1;
        fetch_addr = wa;
        fetch_due.push_back(cycle + 2);
        fetch_q.push_back(model_word(wa));
    endtask

    task automatic check_outputs();
        if (ld_due.size() > 0 && ld_due[0] == cycle) begin
            if (lsu_load_valid !== 1'b1) begin
                $display("missing lsu_load_valid pulse at %0t", $time);
                pulse_errors++;
            end else if (lsu_load_data !== ld_exp[0]) begin
                $display("error at %0t: load data expected %h, got %h",
                         $time, ld_exp[0], lsu_load_data);
                data_errors++;
            end
            void'(ld_due.pop_front());
            void'(ld_exp.pop_front());
        end else if (lsu_load_valid !== 1'b0) begin
            $display("unexpected lsu_load_valid pulse at %0t with no load due", $time);
            pulse_errors++;
        end

        if (mis_due.size() > 0 && mis_due[0] == cycle) begin
            if (lsu_misaligned !== 1'b1) begin
                $display("missing lsu_misaligned pulse at %0t", $time);
                pulse_errors++;
            end
            void'(mis_due.pop_front());
        end else if (lsu_misaligned !== 1'b0) begin
            $display("unexpected lsu_misaligned pulse at %0t", $time);
            pulse_errors++;
        end

        // fetch_data must keep the last result until the next one is due
        if (fetch_due.size() > 0 && fetch_due[0] == cycle) begin
            fetch_exp   = fetch_q[0];
            fetch_known = 1'b1;
            void'(fetch_due.pop_front());
            void'(fetch_q.pop_front());
        end
        if (fetch_known && fetch_data !== fetch_exp) begin
            $display("error at %0t: fetch data expected %h, got %h",
                     $time, fetch_exp, fetch_data);
            data_errors++;
        end
    endtask

    // outputs are read 1 ns after the edge, before new inputs are driven
    task automatic next_cycle();
        @(posedge clk);
        #1;
        cycle++;
        check_outputs();
    endtask

    initial begin
        timeout_cycles = 0;
        while (timeout_cycles <= CYCLE_LIMIT) begin
            @(posedge clk);
            timeout_cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("tests failed");
        $finish;
    end

    initial begin
        int unsigned op;
        int unsigned pick;
        byte_addr_t  addr;
        mem_size_t   size;
        logic        sgn;
        word_t       data;

        lcg_state          = LCG_SEED;
        reset              = 1'b1;
        lsu_req            = 1'b0;
        lsu_we             = 1'b0;
        lsu_addr           = '0;
        lsu_size           = '0;
        lsu_signed         = 1'b0;
        lsu_wdata          = '0;
        fetch_en           = 1'b0;
        fetch_addr         = '0;
        fetch_known        = 1'b0;
        fetch_exp          = '0;
        last_store_word    = '0;
        cycle              = 0;
        data_errors        = 0;
        pulse_errors       = 0;

        repeat (4) next_cycle();
        reset = 1'b0;

        // quiet cycles after reset, any pulse here is reported as unexpected
        repeat (5) next_cycle();

        // fill the whole array so the model and the RAM agree everywhere
        for (int w = 0; w < `SCRATCH_NUM_WORDS; w++) begin
            set_idle();
            issue_lsu(1'b1, byte_addr_t'(w * BYTES_PER_WORD), `SCRATCH_SIZE_WORD,
                      1'b0, rand_word());
            next_cycle();
        end

        for (int n = 0; n < N_OPS; n++) begin
            set_idle();
            op   = next_rand() % 10;
            size = mem_size_t'(next_rand() % 3);
            sgn  = next_rand() >= 16'h8000;
            data = rand_word();
            // a quarter of the accesses hit the word of the latest store
            if (next_rand() % 4 == 0) begin
                addr = byte_addr_t'({last_store_word, 2'(next_rand())});
            end else begin
                addr = byte_addr_t'(next_rand());
            end
            // most accesses are aligned, the rest keep their random offset
            if (next_rand() % 4 != 0) begin
                if (size == `SCRATCH_SIZE_HALF) begin
                    addr[0] = 1'b0;
                end else if (size == `SCRATCH_SIZE_WORD) begin
                    addr[1:0] = 2'b00;
                end
            end
            // the fetch goes first so a same-cycle store is not yet modelled
            pick = next_rand() % 8;
            if (pick < 2) begin
                issue_fetch(word_addr_t'(addr / BYTES_PER_WORD));
            end else if (pick < 5) begin
                issue_fetch(word_addr_t'(next_rand()));
            end
            if (op < 4) begin
                issue_lsu(1'b0, addr, size, sgn, data);
            end else if (op < 8) begin
                issue_lsu(1'b1, addr, size, sgn, data);
            end
            next_cycle();
        end

        set_idle();
        repeat (4) next_cycle();
        if (ld_due.size() != 0 || mis_due.size() != 0 || fetch_due.size() != 0) begin
            $display("responses were still outstanding when the run ended");
            pulse_errors++;
        end

        $display("run finished after %0d cycles: %0d data errors, %0d pulse errors",
                 cycle, data_errors, pulse_errors);
        if (data_errors == 0 && pulse_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== dv/scratchpad_mem_assert.sv ====
`timescale 1ns/1ps

`include "scratchpad_consts.svh"

module scratchpad_mem_assert (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       lsu_req,
    input  logic                       lsu_we,
    input  scratchpad_pkg::byte_addr_t lsu_addr,
    input  scratchpad_pkg::mem_size_t  lsu_size,
    input  logic                       lsu_load_valid,
    input  logic                       lsu_misaligned,
    input  logic                       mem_nwe,
    input  scratchpad_pkg::byte_mask_t mem_wmask
);

    logic misaligned_req;
    logic aligned_load;

    // size codes above a halfword are handled as words by the adapter
    assign misaligned_req = lsu_req &&
        ((lsu_size == `SCRATCH_SIZE_HALF && lsu_addr[0]) ||
         (lsu_size >= `SCRATCH_SIZE_WORD && lsu_addr[1:0] != 2'b00));
    assign aligned_load = lsu_req && !lsu_we && !misaligned_req;

    // -------------------------------------------------------------------------
    // response pulses
    // -------------------------------------------------------------------------

    load_valid_has_load: assert property (@(posedge clk) disable iff (reset)
        lsu_load_valid |-> $past(aligned_load, 2))
        else $error("lsu_load_valid without an aligned load two cycles earlier");

    misaligned_follows: assert property (@(posedge clk) disable iff (reset)
        misaligned_req |=> lsu_misaligned)
        else $error("misaligned request not flagged one cycle later");

    misaligned_has_cause: assert property (@(posedge clk) disable iff (reset)
        lsu_misaligned |-> $past(misaligned_req))
        else $error("lsu_misaligned without a misaligned request");

    quiet_in_reset: assert property (@(posedge clk)
        reset |=> !lsu_load_valid && !lsu_misaligned)
        else $error("response pulse while reset is held");

    // -------------------------------------------------------------------------
    // RAM port 0 controls
    // -------------------------------------------------------------------------

    write_has_lanes: assert property (@(posedge clk) disable iff (reset)
        !mem_nwe |-> mem_wmask != '0)
        else $error("RAM write with an empty byte mask");

endmodule

bind scratchpad_mem scratchpad_mem_assert u_assert (
    .clk            (clk),
    .reset          (reset),
    .lsu_req        (lsu_req),
    .lsu_we         (lsu_we),
    .lsu_addr       (lsu_addr),
    .lsu_size       (lsu_size),
    .lsu_load_valid (lsu_load_valid),
    .lsu_misaligned (lsu_misaligned),
    .mem_nwe        (mem_nwe),
    .mem_wmask      (mem_wmask)
);

// ==== verilog/scratchpad_mem.sv ====
`timescale 1ns/1ps

module scratchpad_mem (
    input  logic                       clk,
    input  logic                       reset,

    // load/store path
    input  logic                       lsu_req,
    input  logic                       lsu_we,
    input  scratchpad_pkg::byte_addr_t lsu_addr,
    input  scratchpad_pkg::mem_size_t  lsu_size,
    input  logic                       lsu_signed,
    input  scratchpad_pkg::word_t      lsu_wdata,
    output logic                       lsu_load_valid,
    output scratchpad_pkg::word_t      lsu_load_data,
    output logic                       lsu_misaligned,

    // instruction fetch path, whole words only
    input  logic                       fetch_en,
    input  scratchpad_pkg::word_addr_t fetch_addr,
    output scratchpad_pkg::word_t      fetch_data
);
    import scratchpad_pkg::*;

    logic       mem_nce;
    logic       mem_nwe;
    word_addr_t mem_addr;
    word_t      mem_wdata;
    byte_mask_t mem_wmask;
    word_t      mem_rdata;

    // port 1 takes an active-low enable
    logic       fetch_nce;

    assign fetch_nce = ~fetch_en;

    lsu_mem_port u_lsu (
        .clk            (clk),
        .reset          (reset),
        .lsu_req        (lsu_req),
        .lsu_we         (lsu_we),
        .lsu_addr       (lsu_addr),
        .lsu_size       (lsu_size),
        .lsu_signed     (lsu_signed),
        .lsu_wdata      (lsu_wdata),
        .lsu_load_valid (lsu_load_valid),
        .lsu_load_data  (lsu_load_data),
        .lsu_misaligned (lsu_misaligned),
        .mem_nce        (mem_nce),
        .mem_nwe        (mem_nwe),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_wmask      (mem_wmask),
        .mem_rdata      (mem_rdata)
    );

    // fetch data comes straight from port 1 and holds between fetches
    mem_rtl u_mem (
        .clk    (clk),
        .reset  (reset),
        .nce    (mem_nce),
        .nwe    (mem_nwe),
        .addr   (mem_addr),
        .wdata  (mem_wdata),
        .wmask  (mem_wmask),
        .rdata  (mem_rdata),
        .nce1   (fetch_nce),
        .addr1  (fetch_addr),
        .rdata1 (fetch_data)
    );

endmodule

// ==== verilog/lsu_mem_port.sv ====
`timescale 1ns/1ps

`include "scratchpad_consts.svh"

module lsu_mem_port (
    input  logic                       clk,
    input  logic                       reset,

    // requests from the load/store unit
    input  logic                       lsu_req,
    input  logic                       lsu_we,
    input  scratchpad_pkg::byte_addr_t lsu_addr,
    input  scratchpad_pkg::mem_size_t  lsu_size,
    input  logic                       lsu_signed,
    input  scratchpad_pkg::word_t      lsu_wdata,

    // responses back to the load/store unit
    output logic                       lsu_load_valid,
    output scratchpad_pkg::word_t      lsu_load_data,
    output logic                       lsu_misaligned,

    // RAM port 0
    output logic                       mem_nce,
    output logic                       mem_nwe,
    output scratchpad_pkg::word_addr_t mem_addr,
    output scratchpad_pkg::word_t      mem_wdata,
    output scratchpad_pkg::byte_mask_t mem_wmask,
    input  scratchpad_pkg::word_t      mem_rdata
);
    import scratchpad_pkg::*;

    localparam int WORD_W = $bits(word_t);
    localparam int LANES  = $bits(byte_mask_t);
    localparam int LANE_W = `SCRATCH_LANE_W;
    localparam int OFF_W  = $bits(byte_addr_t) - $bits(word_addr_t);

    logic [OFF_W-1:0] req_off;
    logic             aligned;
    logic             req_ok;
    byte_mask_t       base_mask;

    logic             s1_valid;
    logic [OFF_W-1:0] s1_off;
    mem_size_t        s1_size;
    logic             s1_signed;
    logic             s2_valid;
    logic [OFF_W-1:0] s2_off;
    mem_size_t        s2_size;
    logic             s2_signed;
    word_t            lane_data;

    // ------------------------------------------------------------------------
    // request decode
    // ------------------------------------------------------------------------

    assign req_off  = lsu_addr[OFF_W-1:0];
    assign mem_addr = lsu_addr[$bits(byte_addr_t)-1:OFF_W];

    // natural alignment for each access size
    always_comb begin
        case (lsu_size)
            `SCRATCH_SIZE_BYTE: aligned = 1'b1;
            `SCRATCH_SIZE_HALF: aligned = ~req_off[0];
            default:            aligned = (req_off == '0);
        endcase
    end

    assign req_ok  = lsu_req & aligned;
    assign mem_nce = ~req_ok;
    assign mem_nwe = ~(req_ok & lsu_we);

    // lanes covered by the access before moving them to the byte offset
    always_comb begin
        case (lsu_size)
            `SCRATCH_SIZE_BYTE: base_mask = byte_mask_t'(1);
            `SCRATCH_SIZE_HALF: base_mask = byte_mask_t'(3);
            default:            base_mask = '1;
        endcase
    end

    assign mem_wmask = base_mask << req_off;

    // copy the store value into every lane it could land in
    // and the mask then picks the lanes that get written
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            case (lsu_size)
                `SCRATCH_SIZE_BYTE:
                    mem_wdata[i*LANE_W +: LANE_W] = lsu_wdata[0 +: LANE_W];
                `SCRATCH_SIZE_HALF:
                    mem_wdata[i*LANE_W +: LANE_W] = lsu_wdata[(i % 2)*LANE_W +: LANE_W];
                default:
                    mem_wdata[i*LANE_W +: LANE_W] = lsu_wdata[i*LANE_W +: LANE_W];
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // load response pipeline
    // ------------------------------------------------------------------------

    // stage 1 lines up with the RAM input registers and stage 2 with its
    // read data, so s2 and mem_rdata belong to the same load
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid       <= 1'b0;
            s2_valid       <= 1'b0;
            lsu_misaligned <= 1'b0;
        end else begin
            s1_valid       <= req_ok & ~lsu_we;
            s2_valid       <= s1_valid;
            lsu_misaligned <= lsu_req & ~aligned;
        end
    end

    always_ff @(posedge clk) begin
        s1_off    <= req_off;
        s1_size   <= lsu_size;
        s1_signed <= lsu_signed;
        s2_off    <= s1_off;
        s2_size   <= s1_size;
        s2_signed <= s1_signed;
    end

    assign lsu_load_valid = s2_valid;

    // move the addressed lanes down to bit 0 and extend them
    always_comb begin
        lane_data = mem_rdata >> (s2_off * LANE_W);
        case (s2_size)
            `SCRATCH_SIZE_BYTE:
                lsu_load_data = {{(WORD_W-LANE_W){s2_signed & lane_data[LANE_W-1]}},
                                 lane_data[LANE_W-1:0]};
            `SCRATCH_SIZE_HALF:
                lsu_load_data = {{(WORD_W-2*LANE_W){s2_signed & lane_data[2*LANE_W-1]}},
                                 lane_data[2*LANE_W-1:0]};
            default:
                lsu_load_data = mem_rdata;
        endcase
    end

endmodule

// ==== verilog/mem_rtl.sv ====
`timescale 1ns/1ps

`include "scratchpad_consts.svh"

module mem_rtl #(
    parameter int WORD_SIZE  = `SCRATCH_WORD_W,
    parameter int NUM_WORDS  = `SCRATCH_NUM_WORDS,
    parameter int WRITE_SIZE = `SCRATCH_LANE_W
) (
    input  logic                       clk,
    input  logic                       reset,

    // port 0 reads and writes
    input  logic                       nce,
    input  logic                       nwe,
    input  scratchpad_pkg::word_addr_t addr,
    input  scratchpad_pkg::word_t      wdata,
    input  scratchpad_pkg::byte_mask_t wmask,
    output scratchpad_pkg::word_t      rdata,

    // port 1 only reads
    input  logic                       nce1,
    input  scratchpad_pkg::word_addr_t addr1,
    output scratchpad_pkg::word_t      rdata1
);
    import scratchpad_pkg::*;

    localparam int LANES = WORD_SIZE / WRITE_SIZE;

    word_t      mem_array [NUM_WORDS];

    logic       nce_q;
    logic       nce1_q;
    logic       nwe_q;
    word_addr_t addr_q;
    word_addr_t addr1_q;
    word_t      wdata_q;
    byte_mask_t wmask_q;

    // ------------------------------------------------------------------------
    // input registers
    // ------------------------------------------------------------------------

    // the enables come up inactive so nothing touches the array after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            nce_q  <= 1'b1;
            nce1_q <= 1'b1;
        end else begin
            nce_q  <= nce;
            nce1_q <= nce1;
        end
    end

    always_ff @(posedge clk) begin
        nwe_q   <= nwe;
        addr_q  <= addr;
        addr1_q <= addr1;
        wdata_q <= wdata;
        wmask_q <= wmask;
    end

    // ------------------------------------------------------------------------
    // array access, one edge after the inputs were captured
    // ------------------------------------------------------------------------

    // port 1 reads the array value from before this edge, so a read that
    // meets a port-0 write to the same word gets the old contents
    always_ff @(posedge clk) begin
        if (!nce_q) begin
            if (!nwe_q) begin
                for (int i = 0; i < LANES; i++) begin
                    if (wmask_q[i]) begin
                        mem_array[addr_q][i*WRITE_SIZE +: WRITE_SIZE] <=
                            wdata_q[i*WRITE_SIZE +: WRITE_SIZE];
                    end
                end
            end else begin
                rdata <= mem_array[addr_q];
            end
        end

        // rdata1 keeps its last value while port 1 is idle
        if (!nce1_q) begin
            rdata1 <= mem_array[addr1_q];
        end
    end

endmodule

// ==== verilog/scratchpad_pkg.sv ====
`include "scratchpad_consts.svh"

package scratchpad_pkg;

    // ------------------------------------------------------------------------
    // data and address types
    // ------------------------------------------------------------------------

    // one full RAM word as stored and as returned by either read port
    typedef logic [`SCRATCH_WORD_W-1:0] word_t;

    // index of a word inside the array
    typedef logic [$clog2(`SCRATCH_NUM_WORDS)-1:0] word_addr_t;

    // byte address from the load/store unit
    // the low bits pick the byte inside a word and the rest is the word index
    typedef logic [$clog2(`SCRATCH_NUM_WORDS)
                   + $clog2(`SCRATCH_WORD_W / 8)-1:0] byte_addr_t;

    // ------------------------------------------------------------------------
    // write control types
    // ------------------------------------------------------------------------

    // one enable bit per write lane of a word
    typedef logic [`SCRATCH_WORD_W/`SCRATCH_LANE_W-1:0] byte_mask_t;

    // access size, coded as the SCRATCH_SIZE_* values
    typedef logic [1:0] mem_size_t;

endpackage

// ==== include/scratchpad_consts.svh ====
`ifndef SCRATCHPAD_CONSTS_SVH
`define SCRATCHPAD_CONSTS_SVH

// ----------------------------------------------------------------------------
// memory geometry
// ----------------------------------------------------------------------------

// width of one RAM word in bits
`define SCRATCH_WORD_W 32

// number of words in the array, so the word index is log2 of this wide
`define SCRATCH_NUM_WORDS 1024

// granularity of the port-0 write mask, one mask bit per lane
`define SCRATCH_LANE_W 8

// ----------------------------------------------------------------------------
// access size codes on the load/store port
// ----------------------------------------------------------------------------

`define SCRATCH_SIZE_BYTE 0
`define SCRATCH_SIZE_HALF 1
`define SCRATCH_SIZE_WORD 2

`endif
